//--- design/decode.sv
`timescale 1ns/1ps

module decode (
	input  logic              clk,
	input  logic              rst,
	input  logic              debug_flag,
	input  mips_pkg::if_id_t  if_id,
	input  mips_pkg::mem_wb_t wb,
	input  logic              flush,
	input  logic [4:0]        dbg_addr,
	output mips_pkg::id_ex_t  id_ex,
	output mips_pkg::redirect_t jump,
	output logic              stall,
	output logic [31:0]       reg_dbg
);
	import mips_pkg::*;

	logic [XLEN-1:0] rf [2**REG_AW];
	instr_u          ins;
	exec_ctrl_t      ex_c;
	mem_ctrl_t       mem_c;
	wb_ctrl_t        wb_c;
	logic            is_halt;
	logic            is_jump;
	logic            uses_rs;
	logic            uses_rt;
	id_ex_t          id_ex_d;

	assign ins = if_id.instr;

	// Register 0 reads zero, write-back bypasses the array
	function automatic logic [XLEN-1:0] rf_read(input logic [REG_AW-1:0] addr);
		if (addr == '0)
			return '0;
		if (wb.valid && wb.reg_write && wb.write_reg == addr)
			return wb.write_data;
		return rf[addr];
	endfunction

	always_ff @(posedge clk) begin
		if (wb.valid && wb.reg_write && wb.write_reg != '0)
			rf[wb.write_reg] <= wb.write_data;
	end

	always_comb begin
		reg_dbg = rf_read(dbg_addr);
	end

	//////////////////////////////
	// Control decode
	//////////////////////////////
	always_comb begin
		ex_c    = '{alu_op: ALU_ADD, alu_src_imm: 1'b0, reg_dst_rd: 1'b0};
		mem_c   = '0;
		wb_c    = '0;
		is_halt = 1'b0;
		is_jump = 1'b0;
		uses_rs = 1'b0;
		uses_rt = 1'b0;
		case (ins.r_view.op)
			OP_RTYPE: begin
				ex_c.reg_dst_rd = 1'b1;
				wb_c.reg_write  = 1'b1;
				uses_rs         = 1'b1;
				uses_rt         = 1'b1;
				case (ins.r_view.funct)
					FN_ADDU: ex_c.alu_op = ALU_ADD;
					FN_SUBU: ex_c.alu_op = ALU_SUB;
					FN_AND:  ex_c.alu_op = ALU_AND;
					FN_OR:   ex_c.alu_op = ALU_OR;
					FN_SLT:  ex_c.alu_op = ALU_SLT;
					// Anything else, the zero word included, is a nop
					default: wb_c.reg_write = 1'b0;
				endcase
			end
			OP_ADDIU: begin
				ex_c.alu_src_imm = 1'b1;
				wb_c.reg_write   = 1'b1;
				uses_rs          = 1'b1;
			end
			OP_LW: begin
				ex_c.alu_src_imm = 1'b1;
				mem_c.mem_read   = 1'b1;
				wb_c             = '{reg_write: 1'b1, mem_to_reg: 1'b1};
				uses_rs          = 1'b1;
			end
			OP_SW: begin
				ex_c.alu_src_imm = 1'b1;
				mem_c.mem_write  = 1'b1;
				uses_rs          = 1'b1;
				uses_rt          = 1'b1;
			end
			OP_BEQ: begin
				ex_c.alu_op  = ALU_SUB;
				mem_c.branch = 1'b1;
				uses_rs      = 1'b1;
				uses_rt      = 1'b1;
			end
			OP_J:    is_jump = 1'b1;
			OP_HALT: is_halt = 1'b1;
			default: ;
		endcase
	end

	// Jump resolves here, one bubble
	assign jump.taken  = if_id.valid && is_jump && !flush;
	assign jump.target = {if_id.pc_plus4[31:28], ins.i_view.rs, ins.i_view.rt,
		ins.i_view.imm16, 2'b00};

	// Load-use against the load now in EX
	assign stall = if_id.valid && id_ex.valid && id_ex.mem_ctrl.mem_read &&
		id_ex.rt != '0 &&
		((uses_rs && ins.i_view.rs == id_ex.rt) || (uses_rt && ins.i_view.rt == id_ex.rt));

	//////////////////////////////
	// ID/EX register
	//////////////////////////////
	always_comb begin
		id_ex_d.valid    = if_id.valid;
		id_ex_d.halt     = is_halt;
		id_ex_d.pc_plus4 = if_id.pc_plus4;
		id_ex_d.reg1     = rf_read(ins.r_view.rs);
		id_ex_d.reg2     = rf_read(ins.r_view.rt);
		id_ex_d.imm_ext  = {{16{ins.i_view.imm16[15]}}, ins.i_view.imm16};
		id_ex_d.rs       = ins.r_view.rs;
		id_ex_d.rt       = ins.r_view.rt;
		id_ex_d.rd       = ins.r_view.rd;
		id_ex_d.ex_ctrl  = ex_c;
		id_ex_d.mem_ctrl = mem_c;
		id_ex_d.wb_ctrl  = wb_c;
	end

	always_ff @(posedge clk) begin
		id_ex <= id_ex_d;
		if (rst || debug_flag || flush || stall)
			id_ex.valid <= 1'b0;
	end

endmodule

//--- design/execute.sv
`timescale 1ns/1ps

module execute (
	input  logic              clk,
	input  logic              rst,
	input  logic              debug_flag,
	input  mips_pkg::id_ex_t  id_ex,
	input  mips_pkg::mem_wb_t wb,
	input  logic              flush,
	output mips_pkg::ex_mem_t ex_mem
);
	import mips_pkg::*;

	logic [XLEN-1:0] fwd_a;
	logic [XLEN-1:0] fwd_b;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_out;
	ex_mem_t         ex_mem_d;

	//////////////////////////////
	// Forwarding, youngest first
	//////////////////////////////
	function automatic logic [XLEN-1:0] forward(input logic [REG_AW-1:0] src,
			input logic [XLEN-1:0] reg_val);
		if (src == '0)
			return reg_val;
		if (ex_mem.valid && ex_mem.wb_ctrl.reg_write && ex_mem.write_reg == src)
			return ex_mem.alu_out;
		if (wb.valid && wb.reg_write && wb.write_reg == src)
			return wb.write_data;
		return reg_val;
	endfunction

	always_comb begin
		fwd_a = forward(id_ex.rs, id_ex.reg1);
		fwd_b = forward(id_ex.rt, id_ex.reg2);
		op_b  = id_ex.ex_ctrl.alu_src_imm ? id_ex.imm_ext : fwd_b;
	end

	// ALU
	always_comb begin
		case (id_ex.ex_ctrl.alu_op)
			ALU_ADD: alu_out = fwd_a + op_b;
			ALU_SUB: alu_out = fwd_a - op_b;
			ALU_AND: alu_out = fwd_a & op_b;
			ALU_OR:  alu_out = fwd_a | op_b;
			ALU_SLT: alu_out = {31'd0, $signed(fwd_a) < $signed(op_b)};
			default: alu_out = '0;
		endcase
	end

	always_comb begin
		ex_mem_d.valid         = id_ex.valid;
		ex_mem_d.halt          = id_ex.halt;
		ex_mem_d.branch_target = id_ex.pc_plus4 + {id_ex.imm_ext[29:0], 2'b00};
		ex_mem_d.zero          = (alu_out == '0);
		ex_mem_d.alu_out       = alu_out;
		// SW data is rt after forwarding
		ex_mem_d.store_data    = fwd_b;
		ex_mem_d.write_reg     = id_ex.ex_ctrl.reg_dst_rd ? id_ex.rd : id_ex.rt;
		ex_mem_d.mem_ctrl      = id_ex.mem_ctrl;
		ex_mem_d.wb_ctrl       = id_ex.wb_ctrl;
	end

	always_ff @(posedge clk) begin
		ex_mem <= ex_mem_d;
		if (rst || debug_flag || flush)
			ex_mem.valid <= 1'b0;
	end

endmodule

//--- design/instruction_fetch.sv
`timescale 1ns/1ps

module instruction_fetch (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  debug_flag,
	input  logic                  prog_req,
	input  mips_pkg::prog_write_t prog_wr,
	input  logic                  stall,
	input  mips_pkg::redirect_t   jump,
	input  mips_pkg::redirect_t   branch,
	output logic                  prog_ack,
	output mips_pkg::if_id_t      if_id,
	output logic [31:0]           pc
);
	import mips_pkg::*;

	logic [XLEN-1:0] imem [2**IMEM_AW];
	instr_u          fetch_word;
	logic            halt_seen;

	assign fetch_word = imem[pc[IMEM_AW+1:2]];

	//////////////////////////////
	// Program load, four-phase
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (debug_flag && prog_req && !prog_ack)
			imem[prog_wr.addr] <= prog_wr.data;
	end

	// Ack follows req one cycle later, both edges
	always_ff @(posedge clk) begin
		if (rst)
			prog_ack <= 1'b0;
		else
			prog_ack <= debug_flag && prog_req;
	end

	//////////////////////////////
	// Next pc and IF/ID
	//////////////////////////////
	always_ff @(posedge clk) begin
		if (rst || debug_flag) begin
			pc          <= '0;
			if_id.valid <= 1'b0;
			halt_seen   <= 1'b0;
		end else if (branch.taken) begin
			pc          <= branch.target;
			if_id.valid <= 1'b0;
			halt_seen   <= 1'b0;
		end else if (jump.taken) begin
			pc          <= jump.target;
			if_id.valid <= 1'b0;
			halt_seen   <= 1'b0;
		end else if (stall) begin
			// Hold pc and IF/ID
		end else if (halt_seen) begin
			if_id.valid <= 1'b0;
		end else begin
			if_id.valid    <= 1'b1;
			if_id.pc_plus4 <= pc + 32'd4;
			if_id.instr    <= fetch_word;
			// Park on HALT until redirected or reset
			if (fetch_word.r_view.op == OP_HALT)
				halt_seen <= 1'b1;
			else
				pc <= pc + 32'd4;
		end
	end

endmodule

//--- design/memory.sv
`timescale 1ns/1ps

module memory (
	input  logic                clk,
	input  logic                rst,
	input  logic                debug_flag,
	input  mips_pkg::ex_mem_t   ex_mem,
	input  logic [31:0]         dbg_addr,
	output mips_pkg::redirect_t branch,
	output mips_pkg::mem_wb_t   wb,
	output logic [31:0]         mem_dbg
);
	import mips_pkg::*;

	logic [XLEN-1:0] dmem [2**DMEM_AW];
	logic [XLEN-1:0] read_data;
	mem_wb_t         wb_d;

	//////////////////////////////
	// Data memory
	//////////////////////////////
	// Word-indexed by byte address bits
	assign read_data = dmem[ex_mem.alu_out[DMEM_AW+1:2]];
	assign mem_dbg   = dmem[dbg_addr[DMEM_AW+1:2]];

	always_ff @(posedge clk) begin
		if (ex_mem.valid && ex_mem.mem_ctrl.mem_write && !debug_flag)
			dmem[ex_mem.alu_out[DMEM_AW+1:2]] <= ex_mem.store_data;
	end

	// BEQ resolves here
	assign branch.taken  = ex_mem.valid && ex_mem.mem_ctrl.branch && ex_mem.zero;
	assign branch.target = ex_mem.branch_target;

	//////////////////////////////
	// MEM/WB register
	//////////////////////////////
	always_comb begin
		wb_d.valid      = ex_mem.valid;
		wb_d.halt       = ex_mem.halt;
		wb_d.write_reg  = ex_mem.write_reg;
		wb_d.write_data = ex_mem.wb_ctrl.mem_to_reg ? read_data : ex_mem.alu_out;
		wb_d.reg_write  = ex_mem.wb_ctrl.reg_write;
	end

	always_ff @(posedge clk) begin
		wb <= wb_d;
		if (rst || debug_flag)
			wb.valid <= 1'b0;
	end

endmodule

//--- design/mips_pkg.sv
package mips_pkg;

	//////////////////////////////
	// Sizes
	//////////////////////////////
	localparam int XLEN    = 32;
	localparam int REG_AW  = 5;
	localparam int IMEM_AW = 6;
	localparam int DMEM_AW = 6;

	// Primary opcodes
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDIU = 6'h09;
	localparam logic [5:0] OP_LW    = 6'h23;
	localparam logic [5:0] OP_SW    = 6'h2B;
	localparam logic [5:0] OP_BEQ   = 6'h04;
	localparam logic [5:0] OP_J     = 6'h02;
	localparam logic [5:0] OP_HALT  = 6'h3F;

	// R-type function codes
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_SLT  = 6'h2A;

	//////////////////////////////
	// Instruction word
	//////////////////////////////
	typedef struct packed {
		logic [5:0]        op;
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
		logic [REG_AW-1:0] rd;
		logic [4:0]        shamt;
		logic [5:0]        funct;
	} r_view_t;

	// J target is {rs, rt, imm16} of this view
	typedef struct packed {
		logic [5:0]        op;
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
		logic [15:0]       imm16;
	} i_view_t;

	typedef union packed {
		r_view_t r_view;
		i_view_t i_view;
	} instr_u;

	//////////////////////////////
	// Control fields
	//////////////////////////////
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    alu_src_imm;
		logic    reg_dst_rd;
	} exec_ctrl_t;

	typedef struct packed {
		logic mem_read;
		logic mem_write;
		logic branch;
	} mem_ctrl_t;

	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
	} wb_ctrl_t;

	//////////////////////////////
	// Stage registers
	//////////////////////////////
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] pc_plus4;
		instr_u          instr;
	} if_id_t;

	typedef struct packed {
		logic              valid;
		logic              halt;
		logic [XLEN-1:0]   pc_plus4;
		logic [XLEN-1:0]   reg1;
		logic [XLEN-1:0]   reg2;
		logic [XLEN-1:0]   imm_ext;
		logic [REG_AW-1:0] rs;
		logic [REG_AW-1:0] rt;
		logic [REG_AW-1:0] rd;
		exec_ctrl_t        ex_ctrl;
		mem_ctrl_t         mem_ctrl;
		wb_ctrl_t          wb_ctrl;
	} id_ex_t;

	typedef struct packed {
		logic              valid;
		logic              halt;
		logic [XLEN-1:0]   branch_target;
		logic              zero;
		logic [XLEN-1:0]   alu_out;
		logic [XLEN-1:0]   store_data;
		logic [REG_AW-1:0] write_reg;
		mem_ctrl_t         mem_ctrl;
		wb_ctrl_t          wb_ctrl;
	} ex_mem_t;

	// Also the write-back and forwarding bus
	typedef struct packed {
		logic              valid;
		logic              halt;
		logic [REG_AW-1:0] write_reg;
		logic [XLEN-1:0]   write_data;
		logic              reg_write;
	} mem_wb_t;

	// Ports
	typedef struct packed {
		logic [IMEM_AW-1:0] addr;
		logic [XLEN-1:0]    data;
	} prog_write_t;

	typedef struct packed {
		logic            taken;
		logic [XLEN-1:0] target;
	} redirect_t;

endpackage

//--- design/top_mips.sv
`timescale 1ns/1ps

module top_mips (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  debug_flag,
	input  logic                  prog_req,
	input  mips_pkg::prog_write_t prog_wr,
	input  logic [31:0]           dbg_addr,
	output logic                  prog_ack,
	output logic [31:0]           reg_dbg,
	output logic [31:0]           mem_dbg,
	output logic [31:0]           pc,
	output logic                  halt_flag
);
	import mips_pkg::*;

	if_id_t    if_id;
	id_ex_t    id_ex;
	ex_mem_t   ex_mem;
	mem_wb_t   wb;
	redirect_t jump;
	redirect_t branch;
	logic      stall;

	instruction_fetch u_instruction_fetch (
		.clk        (clk),
		.rst        (rst),
		.debug_flag (debug_flag),
		.prog_req   (prog_req),
		.prog_wr    (prog_wr),
		.stall      (stall),
		.jump       (jump),
		.branch     (branch),
		.prog_ack   (prog_ack),
		.if_id      (if_id),
		.pc         (pc)
	);

	decode u_decode (
		.clk        (clk),
		.rst        (rst),
		.debug_flag (debug_flag),
		.if_id      (if_id),
		.wb         (wb),
		.flush      (branch.taken),
		.dbg_addr   (dbg_addr[REG_AW-1:0]),
		.id_ex      (id_ex),
		.jump       (jump),
		.stall      (stall),
		.reg_dbg    (reg_dbg)
	);

	execute u_execute (
		.clk        (clk),
		.rst        (rst),
		.debug_flag (debug_flag),
		.id_ex      (id_ex),
		.wb         (wb),
		.flush      (branch.taken),
		.ex_mem     (ex_mem)
	);

	memory u_memory (
		.clk        (clk),
		.rst        (rst),
		.debug_flag (debug_flag),
		.ex_mem     (ex_mem),
		.dbg_addr   (dbg_addr),
		.branch     (branch),
		.wb         (wb),
		.mem_dbg    (mem_dbg)
	);

	// Sticky until the host takes the core back
	always_ff @(posedge clk) begin
		if (rst || debug_flag)
			halt_flag <= 1'b0;
		else if (wb.valid && wb.halt)
			halt_flag <= 1'b1;
	end

endmodule

//--- src.f
design/mips_pkg.sv
design/instruction_fetch.sv
design/decode.sv
design/execute.sv
design/memory.sv
design/top_mips.sv
test/mips_iss_pkg.sv
test/tb_top_mips.sv

//--- test/mips_iss_pkg.sv
package mips_iss_pkg;
	import mips_pkg::*;

	// Program layout in words
	localparam int PROLOGUE = 15;
	localparam int BODY_LEN = 40;
	localparam int HALT_IDX = PROLOGUE + BODY_LEN;
	localparam int PROG_LEN = HALT_IDX + 1;

	integer      rng_seed;
	logic [31:0] prog [64];
	logic [31:0] model_regs [32];
	logic [31:0] model_mem [64];
	int          model_steps;

	function automatic int unsigned rnd(input int unsigned n);
		return $unsigned($random(rng_seed)) % n;
	endfunction

	// Registers 1 to 7 only
	function automatic logic [4:0] rand_reg();
		return 5'(1 + rnd(7));
	endfunction

	function automatic logic [31:0] enc_r(input logic [5:0] funct, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd);
		return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	//////////////////////////////
	// Random program
	//////////////////////////////
	task automatic gen_program(input integer s);
		int j_at;
		int off;
		rng_seed = s;
		// Seed every register and every store word before the body
		for (int r = 1; r < 8; r++)
			prog[r-1] = enc_i(OP_ADDIU, 5'd0, 5'(r), 16'(rnd(65536)));
		for (int k = 0; k < 8; k++)
			prog[7+k] = enc_i(OP_SW, 5'd0, rand_reg(), 16'(4 * k));
		j_at = PROLOGUE + 5 + rnd(BODY_LEN - 10);
		for (int idx = PROLOGUE; idx < HALT_IDX; idx++) begin
			if (idx == j_at) begin
				prog[idx] = {OP_J, 26'(idx + 2 + rnd(4))};
			end else begin
				case (rnd(9))
					0: prog[idx] = enc_r(FN_ADDU, rand_reg(), rand_reg(), rand_reg());
					1: prog[idx] = enc_r(FN_SUBU, rand_reg(), rand_reg(), rand_reg());
					2: prog[idx] = enc_r(FN_AND, rand_reg(), rand_reg(), rand_reg());
					3: prog[idx] = enc_r(FN_OR, rand_reg(), rand_reg(), rand_reg());
					4: prog[idx] = enc_r(FN_SLT, rand_reg(), rand_reg(), rand_reg());
					5: prog[idx] = enc_i(OP_ADDIU, rand_reg(), rand_reg(), 16'(rnd(65536)));
					6: prog[idx] = enc_i(OP_LW, 5'd0, rand_reg(), 16'(4 * rnd(8)));
					7: prog[idx] = enc_i(OP_SW, 5'd0, rand_reg(), 16'(4 * rnd(8)));
					default: begin
						// Forward only, never past HALT
						off = rnd(4);
						if (idx + 1 + off > HALT_IDX)
							off = HALT_IDX - idx - 1;
						prog[idx] = enc_i(OP_BEQ, rand_reg(), rand_reg(), 16'(off));
					end
				endcase
			end
		end
		prog[HALT_IDX] = {OP_HALT, 26'd0};
	endtask

	//////////////////////////////
	// Instruction-set model
	//////////////////////////////
	function automatic void set_reg(input logic [4:0] r, input logic [31:0] value);
		if (r != 5'd0)
			model_regs[r] = value;
	endfunction

	task automatic run_model();
		int          pc;
		logic [31:0] ins;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] addr;
		for (int i = 0; i < 32; i++)
			model_regs[i] = '0;
		for (int i = 0; i < 64; i++)
			model_mem[i] = '0;
		pc          = 0;
		model_steps = 0;
		while (pc < 64 && prog[pc][31:26] != OP_HALT && model_steps < 1000) begin
			ins  = prog[pc];
			a    = model_regs[ins[25:21]];
			b    = model_regs[ins[20:16]];
			imm  = {{16{ins[15]}}, ins[15:0]};
			addr = a + imm;
			pc   = pc + 1;
			case (ins[31:26])
				OP_RTYPE: begin
					case (ins[5:0])
						FN_ADDU: set_reg(ins[15:11], a + b);
						FN_SUBU: set_reg(ins[15:11], a - b);
						FN_AND:  set_reg(ins[15:11], a & b);
						FN_OR:   set_reg(ins[15:11], a | b);
						FN_SLT:  set_reg(ins[15:11], ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
						default: ;
					endcase
				end
				OP_ADDIU: set_reg(ins[20:16], addr);
				OP_LW:    set_reg(ins[20:16], model_mem[addr[DMEM_AW+1:2]]);
				OP_SW:    model_mem[addr[DMEM_AW+1:2]] = b;
				OP_BEQ:   if (a == b) pc = pc + $signed(imm);
				OP_J:     pc = ins[25:0];
				default:  ;
			endcase
			model_steps++;
		end
	endtask

endpackage

//--- test/tb_top_mips.sv
`timescale 1ns/1ps

module tb_top_mips;
	import mips_pkg::*;
	import mips_iss_pkg::*;

	localparam int ACK_TIMEOUT  = 16;
	localparam int HALT_TIMEOUT = 2000;

	logic        clk;
	logic        rst;
	logic        debug_flag;
	logic        prog_req;
	prog_write_t prog_wr;
	logic [31:0] dbg_addr;
	logic        prog_ack;
	logic [31:0] reg_dbg;
	logic [31:0] mem_dbg;
	logic [31:0] pc;
	logic        halt_flag;

	integer seed;
	int     errors;
	int     tests;
	int     errors_before;

	top_mips DUT (
		.clk        (clk),
		.rst        (rst),
		.debug_flag (debug_flag),
		.prog_req   (prog_req),
		.prog_wr    (prog_wr),
		.dbg_addr   (dbg_addr),
		.prog_ack   (prog_ack),
		.reg_dbg    (reg_dbg),
		.mem_dbg    (mem_dbg),
		.pc         (pc),
		.halt_flag  (halt_flag)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// Watchdog for the whole run
	initial begin
		#200000;
		$display("Simulation ran past its time limit, giving up");
		$display("Test failed");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("** Error %s: expected %h, got %h", name, expected, actual);
			errors++;
		end
	endtask

	//////////////////////////////
	// Host side of the port
	//////////////////////////////
	task automatic wait_ack(input logic level);
		int cycles;
		cycles = 0;
		while (prog_ack !== level && cycles < ACK_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (prog_ack !== level) begin
			$display("prog_ack did not go to %0d within %0d cycles", level, ACK_TIMEOUT);
			errors++;
		end
	endtask

	task automatic load_word(input int addr, input logic [31:0] data);
		@(negedge clk);
		prog_wr.addr = addr[IMEM_AW-1:0];
		prog_wr.data = data;
		prog_req     = 1'b1;
		wait_ack(1'b1);
		prog_req = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic load_program(input int len);
		for (int i = 0; i < len; i++)
			load_word(i, prog[i]);
	endtask

	task automatic enter_debug();
		@(negedge clk);
		debug_flag = 1'b1;
		repeat (2) @(negedge clk);
	endtask

	task automatic wait_halt();
		int cycles;
		cycles = 0;
		while (halt_flag !== 1'b1 && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		if (halt_flag !== 1'b1) begin
			$display("halt_flag did not rise within %0d cycles", HALT_TIMEOUT);
			errors++;
		end
	endtask

	// A halted core stays parked
	task automatic check_parked();
		logic [31:0] pc_halted;
		pc_halted = pc;
		repeat (10) begin
			@(negedge clk);
			check_value("halt_flag", 32'd1, {31'd0, halt_flag});
			check_value("pc", pc_halted, pc);
		end
	endtask

	task automatic check_registers();
		string name;
		for (int r = 0; r < 8; r++) begin
			@(negedge clk);
			dbg_addr = r;
			#2;
			name = $sformatf("reg_dbg[%0d]", r);
			check_value(name, model_regs[r], reg_dbg);
		end
	endtask

	// Byte addresses of the eight store words
	task automatic check_memory();
		string name;
		for (int k = 0; k < 8; k++) begin
			@(negedge clk);
			dbg_addr = 4 * k;
			#2;
			name = $sformatf("mem_dbg[%0d]", 4 * k);
			check_value(name, model_mem[k], mem_dbg);
		end
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == errors_before)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, errors - errors_before);
		errors_before = errors;
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////
	initial begin
		rst           = 1'b1;
		debug_flag    = 1'b1;
		prog_req      = 1'b0;
		prog_wr       = '0;
		dbg_addr      = '0;
		seed          = 9;
		errors        = 0;
		tests         = 0;
		errors_before = 0;
		repeat (8) @(negedge clk);
		rst = 1'b0;

		// One ADDIU then HALT
		load_word(0, enc_i(OP_ADDIU, 5'd0, 5'd1, 16'h5A3C));
		load_word(1, {OP_HALT, 26'd0});
		@(negedge clk);
		check_value("prog_ack", 32'd0, {31'd0, prog_ack});
		debug_flag = 1'b0;
		wait_halt();
		@(negedge clk);
		dbg_addr = 32'd1;
		#2;
		check_value("reg_dbg[1]", 32'h0000_5A3C, reg_dbg);
		finish_test("program load");

		enter_debug();
		gen_program(seed);
		run_model();
		load_program(PROG_LEN);
		@(negedge clk);
		debug_flag = 1'b0;
		wait_halt();
		check_parked();
		finish_test("halt");
		check_registers();
		finish_test("registers");
		check_memory();
		finish_test("data memory");

		// A reset while halted restarts the program
		@(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		check_value("halt_flag", 32'd0, {31'd0, halt_flag});
		check_value("pc", 32'd0, pc);
		rst = 1'b0;

		// Another reset in the middle of the rerun
		repeat (12) @(negedge clk);
		rst = 1'b1;
		@(negedge clk);
		check_value("prog_ack", 32'd0, {31'd0, prog_ack});
		check_value("halt_flag", 32'd0, {31'd0, halt_flag});
		check_value("pc", 32'd0, pc);
		@(negedge clk);
		rst = 1'b0;
		wait_halt();
		check_registers();
		check_memory();
		finish_test("reset");

		$display("Summary: %0d tests, %0d errors", tests, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule
